// ==== bench/uart_top_chk.sv ====
`timescale 1ns/1ps

module uart_top_chk (
    input logic                clk,
    input logic                rst,
    input logic                awvalid,
    input logic                awready,
    input logic                arvalid,
    input logic                arready,
    input logic                bvalid,
    input logic                bready,
    input axil_pkg::axi_resp_e bresp,
    input logic                rvalid,
    input logic                rready,
    input logic [31:0]         rdata,
    input axil_pkg::axi_resp_e rresp,
    input logic                tx,
    input logic                tx_busy
);
    int fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4-Lite handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    aw_held: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid)
        else begin
            fail_count++;
            $error("awvalid dropped before awready");
        end

    ar_held: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid)
        else begin
            fail_count++;
            $error("arvalid dropped before arready");
        end

    b_stable: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            fail_count++;
            $error("Write response changed while stalled");
        end

    r_stable: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            fail_count++;
            $error("Read response changed while stalled");
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial line
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    tx_idle_high: assert property (@(posedge clk) disable iff (rst)
        !tx_busy |-> tx)
        else begin
            fail_count++;
            $error("tx low while transmitter idle");
        end

endmodule

bind uart_top uart_top_chk chk (
    .clk, .rst, .awvalid, .awready, .arvalid, .arready,
    .bvalid, .bready, .bresp, .rvalid, .rready, .rdata, .rresp,
    .tx, .tx_busy
);

// ==== bench/uart_top_tb.sv ====
`timescale 1ns/1ps

module uart_top_tb;
    import uart_pkg::*;
    import axil_pkg::*;

    localparam int         CLK_PERIOD   = 40;
    localparam int         FRAME_CYCLES = CLK_PER_BIT * 10;
    localparam logic [7:0] S_RXV        = 8'(1 << ST_RX_VALID);
    localparam logic [7:0] S_OVR        = 8'(1 << ST_OVERRUN);
    localparam logic [7:0] S_FERR       = 8'(1 << ST_FRAME_ERR);

    typedef enum {OP_READ, OP_WRITE, OP_SEND, OP_SEND_BAD, OP_POLL} op_e;

    typedef struct {
        string      name;
        op_e        op;
        logic [3:0] addr;
        logic [7:0] data;
        axi_resp_e  resp;
        logic [7:0] exp;      // Byte or status, by address.
    } entry_t;

    logic        clk, rst;
    logic [3:0]  awaddr, araddr, wstrb;
    logic [31:0] wdata, rdata;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    axi_resp_e   bresp, rresp;
    logic        rx, tx, ser_line, use_loop;

    entry_t      tests[$];
    logic [31:0] lfsr = 32'd92614;
    int          errors = 0;

    assign rx = use_loop ? tx : ser_line;              // Loopback or serializer.

    uart_top DUT (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .rx, .tx
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic add_test(input string name, input op_e op, input logic [3:0] addr,
                            input logic [7:0] data, input axi_resp_e resp,
                            input logic [7:0] exp);
        tests.push_back(entry_t'{name, op, addr, data, resp, exp});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
        if (act !== exp) begin
            errors++;
            $display("Error: %s resp expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error: %s data expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input logic [3:0] exp,
                                input logic [3:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error: %s status expected %h actual %h", name, exp, act);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI master and serializer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output axi_resp_e resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);                                // Transfer done on the last edge.
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        repeat (2) @(negedge clk);                     // Stall the response.
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output axi_resp_e resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        repeat (2) @(negedge clk);                     // Stall the response.
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
    endtask

    task automatic poll_status(input string name, input logic [3:0] exp);
        logic [31:0] data;
        axi_resp_e   resp;
        int          tries;
        tries = 0;
        do begin
            axi_read(ADDR_STATUS, data, resp);
            tries++;
        end while (data[3:0] !== exp && tries < 2 * FRAME_CYCLES);
        if (data[3:0] !== exp) begin
            errors++;
            $display("%s: STATUS never reached %h, last read was %h", name, exp, data[3:0]);
        end
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [DATA_BITS+1:0] frame;
        frame    = {stop_bit, data, 1'b0};
        use_loop = 1'b0;
        for (int i = 0; i < DATA_BITS + 2; i++) begin
            ser_line = frame[i];                       // Start, data LSB first, stop.
            repeat (CLK_PER_BIT) @(negedge clk);
        end
        ser_line = 1'b1;
        repeat (CLK_PER_BIT) @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table and run
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [7:0]  b0, b1, b2, b3, b4;
        logic [31:0] data;
        axi_resp_e   resp;
        rst      = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b1;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b1;
        ser_line = 1'b1;
        use_loop = 1'b1;
        draw_byte(b0);
        draw_byte(b1);
        draw_byte(b2);
        draw_byte(b3);
        draw_byte(b4);
        add_test("reset_status", OP_READ, ADDR_STATUS, 8'h00, RESP_OKAY, 8'h00);
        add_test("loop_write", OP_WRITE, ADDR_DATA, b0, RESP_OKAY, 8'h00);
        add_test("busy_write", OP_WRITE, ADDR_DATA, b1, RESP_SLVERR, 8'h00);
        add_test("loop_wait", OP_POLL, ADDR_STATUS, 8'h00, RESP_OKAY, S_RXV);
        add_test("loop_data", OP_READ, ADDR_DATA, 8'h00, RESP_OKAY, b0);
        add_test("loop_cleared", OP_READ, ADDR_STATUS, 8'h00, RESP_OKAY, 8'h00);
        add_test("ovr_first", OP_SEND, ADDR_DATA, b2, RESP_OKAY, 8'h00);
        add_test("ovr_second", OP_SEND, ADDR_DATA, b3, RESP_OKAY, 8'h00);
        add_test("ovr_wait", OP_POLL, ADDR_STATUS, 8'h00, RESP_OKAY, S_RXV | S_OVR);
        add_test("ovr_data", OP_READ, ADDR_DATA, 8'h00, RESP_OKAY, b3);
        add_test("ovr_clear", OP_WRITE, ADDR_STATUS, 8'hFF, RESP_OKAY, 8'h00);
        add_test("ovr_cleared", OP_READ, ADDR_STATUS, 8'h00, RESP_OKAY, 8'h00);
        add_test("bad_stop", OP_SEND_BAD, ADDR_DATA, b4, RESP_OKAY, 8'h00);
        add_test("ferr_wait", OP_POLL, ADDR_STATUS, 8'h00, RESP_OKAY, S_FERR);
        add_test("ferr_clear", OP_WRITE, ADDR_STATUS, S_FERR, RESP_OKAY, 8'h00);
        add_test("ferr_cleared", OP_READ, ADDR_STATUS, 8'h00, RESP_OKAY, 8'h00);
        add_test("unmapped_read", OP_READ, 4'h8, 8'h00, RESP_DECERR, 8'h00);
        add_test("unmapped_write", OP_WRITE, 4'hC, 8'h5A, RESP_DECERR, 8'h00);

        repeat (8) @(negedge clk);
        rst = 1'b0;
        foreach (tests[i]) begin
            case (tests[i].op)
                OP_READ: begin
                    axi_read(tests[i].addr, data, resp);
                    check_resp(tests[i].name, tests[i].resp, resp);
                    if (tests[i].addr == ADDR_DATA) begin
                        check_byte(tests[i].name, tests[i].exp, data[7:0]);
                    end else if (tests[i].addr == ADDR_STATUS) begin
                        check_status(tests[i].name, tests[i].exp[3:0], data[3:0]);
                    end
                end
                OP_WRITE: begin
                    use_loop = 1'b1;
                    axi_write(tests[i].addr, {24'd0, tests[i].data}, resp);
                    check_resp(tests[i].name, tests[i].resp, resp);
                end
                OP_SEND:     send_frame(tests[i].data, 1'b1);
                OP_SEND_BAD: send_frame(tests[i].data, 1'b0);
                default:     poll_status(tests[i].name, tests[i].exp[3:0]);
            endcase
        end

        $display("Errors: %0d check, %0d assertion", errors, DUT.chk.fail_count);
        if (errors == 0 && DUT.chk.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Twelve frame times per table entry.
    initial begin
        #1;
        #(tests.size() * 12 * FRAME_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d frame times", tests.size() * 12);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/uart_pkg.sv
verilog/axil_pkg.sv
verilog/serial_rx.sv
verilog/serial_tx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
bench/uart_top_chk.sv
bench/uart_top_tb.sv

// ==== verilog/axil_pkg.sv ====
package axil_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // Byte offsets of the register map.
    typedef enum logic [3:0] {
        ADDR_DATA   = 4'h0,
        ADDR_STATUS = 4'h4
    } reg_addr_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // STATUS register bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ST_RX_VALID  = 0;
    localparam int ST_TX_BUSY   = 1;
    localparam int ST_OVERRUN   = 2;   // Write 1 to clear.
    localparam int ST_FRAME_ERR = 3;   // Write 1 to clear.

endpackage

// ==== verilog/serial_rx.sv ====
`timescale 1ns/1ps

module serial_rx (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rx,
    output logic [uart_pkg::DATA_BITS-1:0] rx_byte,
    output logic                           new_data,
    output logic                           frame_err
);
    import uart_pkg::*;

    rx_state_e                    state_d, state_q;
    logic [CTR_SIZE-1:0]          ctr_d, ctr_q;
    logic [$clog2(DATA_BITS)-1:0] bit_ctr_d, bit_ctr_q;
    logic [DATA_BITS-1:0]         data_d, data_q;
    logic                         new_data_d, new_data_q;
    logic                         frame_err_d, frame_err_q;
    logic                         rx_q;

    assign rx_byte   = data_q;
    assign new_data  = new_data_q;
    assign frame_err = frame_err_q;

    always_comb begin
        state_d     = state_q;
        ctr_d       = ctr_q;
        bit_ctr_d   = bit_ctr_q;
        data_d      = data_q;
        new_data_d  = 1'b0;
        frame_err_d = 1'b0;

        case (state_q)
            RX_IDLE: begin
                ctr_d     = '0;
                bit_ctr_d = '0;
                if (!rx_q) begin                      // Start edge.
                    state_d = RX_WAIT_HALF;
                end
            end
            RX_WAIT_HALF: begin
                ctr_d = ctr_q + 1'b1;
                if (ctr_q == CTR_SIZE'(CLK_PER_BIT / 2)) begin
                    ctr_d   = '0;
                    state_d = RX_WAIT_FULL;
                end
            end
            RX_WAIT_FULL: begin
                ctr_d = ctr_q + 1'b1;
                if (ctr_q == CTR_SIZE'(CLK_PER_BIT - 1)) begin
                    ctr_d     = '0;
                    data_d    = {rx_q, data_q[DATA_BITS-1:1]};   // LSB first.
                    bit_ctr_d = bit_ctr_q + 1'b1;
                    if (bit_ctr_q == DATA_BITS - 1) begin
                        state_d = RX_WAIT_STOP;
                    end
                end
            end
            RX_WAIT_STOP: begin
                ctr_d = ctr_q + 1'b1;
                if (ctr_q == CTR_SIZE'(CLK_PER_BIT - 1)) begin
                    new_data_d  = rx_q;
                    frame_err_d = !rx_q;              // Low stop bit.
                    state_d     = RX_WAIT_HIGH;
                end
            end
            RX_WAIT_HIGH: begin
                if (rx_q) begin
                    state_d = RX_IDLE;
                end
            end
            default: begin
                state_d = RX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= RX_IDLE;
            ctr_q       <= '0;
            bit_ctr_q   <= '0;
            new_data_q  <= 1'b0;
            frame_err_q <= 1'b0;
            rx_q        <= 1'b1;                      // Idle line level.
        end else begin
            state_q     <= state_d;
            ctr_q       <= ctr_d;
            bit_ctr_q   <= bit_ctr_d;
            new_data_q  <= new_data_d;
            frame_err_q <= frame_err_d;
            rx_q        <= rx;
        end
        data_q <= data_d;
    end

endmodule

// ==== verilog/serial_tx.sv ====
`timescale 1ns/1ps

module serial_tx (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           tx_start,
    input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
    output logic                           tx,
    output logic                           tx_busy
);
    import uart_pkg::*;

    tx_state_e                    state_d, state_q;
    logic [CTR_SIZE-1:0]          ctr_d, ctr_q;
    logic [$clog2(DATA_BITS)-1:0] bit_ctr_d, bit_ctr_q;
    logic [DATA_BITS-1:0]         data_d, data_q;
    logic                         tx_d, tx_q;
    logic                         bit_end;

    assign bit_end = (ctr_q == CTR_SIZE'(CLK_PER_BIT - 1));
    assign tx      = tx_q;
    assign tx_busy = (state_q != TX_IDLE);

    always_comb begin
        state_d   = state_q;
        ctr_d     = ctr_q + 1'b1;
        bit_ctr_d = bit_ctr_q;
        data_d    = data_q;

        case (state_q)
            TX_IDLE: begin
                ctr_d     = '0;
                bit_ctr_d = '0;
                if (tx_start) begin
                    data_d  = tx_data;
                    state_d = TX_START;
                end
            end
            TX_START: begin
                if (bit_end) begin
                    ctr_d   = '0;
                    state_d = TX_DATA;
                end
            end
            TX_DATA: begin
                if (bit_end) begin
                    ctr_d     = '0;
                    data_d    = data_q >> 1;        // Next bit into position 0.
                    bit_ctr_d = bit_ctr_q + 1'b1;
                    if (bit_ctr_q == DATA_BITS - 1) begin
                        state_d = TX_STOP;
                    end
                end
            end
            TX_STOP: begin
                if (bit_end) begin
                    state_d = TX_IDLE;
                end
            end
            default: begin
                state_d = TX_IDLE;
            end
        endcase

        // Line level follows the next state so each bit starts on a clean edge.
        case (state_d)
            TX_START: tx_d = 1'b0;
            TX_DATA:  tx_d = data_d[0];
            default:  tx_d = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= TX_IDLE;
            ctr_q     <= '0;
            bit_ctr_q <= '0;
            tx_q      <= 1'b1;
        end else begin
            state_q   <= state_d;
            ctr_q     <= ctr_d;
            bit_ctr_q <= bit_ctr_d;
            tx_q      <= tx_d;
        end
        data_q <= data_d;
    end

endmodule

// ==== verilog/uart_pkg.sv ====
package uart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial framing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int CLK_PER_BIT = 16;                   // Clock cycles per serial bit.
    localparam int CTR_SIZE    = $clog2(CLK_PER_BIT);  // Bit-period counter width.
    localparam int DATA_BITS   = 8;                    // 8N1 frames only.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State machines
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_WAIT_HALF,      // Centering on the start bit.
        RX_WAIT_FULL,      // Data bits.
        RX_WAIT_STOP,
        RX_WAIT_HIGH       // Line must return high before the next frame.
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

// ==== verilog/uart_regs.sv ====
`timescale 1ns/1ps

module uart_regs (
    input  logic                clk,
    input  logic                rst,
    // Write channels.
    input  logic [3:0]          awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output axil_pkg::axi_resp_e bresp,
    output logic                bvalid,
    input  logic                bready,
    // Read channels.
    input  logic [3:0]          araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output axil_pkg::axi_resp_e rresp,
    output logic                rvalid,
    input  logic                rready,
    // UART side.
    input  logic [7:0]          rx_byte,
    input  logic                new_data,
    input  logic                frame_err,
    input  logic                tx_busy,
    output logic                tx_start,
    output logic [7:0]          tx_data
);
    import axil_pkg::*;

    logic       wr_ready_q;
    logic       wr_fire, rd_fire, data_rd;
    axi_resp_e  wr_resp;
    logic       wr_tx, clr_overrun, clr_frame;
    logic       rx_valid_q, overrun_q, frame_err_q;
    logic [7:0] rx_hold_q;
    logic [3:0] status;

    assign awready = wr_ready_q;                      // Address and data accepted together.
    assign wready  = wr_ready_q;
    assign wr_fire = wr_ready_q && awvalid && wvalid;
    assign rd_fire = arready && arvalid;
    assign data_rd = rd_fire && (araddr == ADDR_DATA);

    always_comb begin
        status               = '0;
        status[ST_RX_VALID]  = rx_valid_q;
        status[ST_TX_BUSY]   = tx_busy;
        status[ST_OVERRUN]   = overrun_q;
        status[ST_FRAME_ERR] = frame_err_q;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        wr_resp     = RESP_OKAY;
        wr_tx       = 1'b0;
        clr_overrun = 1'b0;
        clr_frame   = 1'b0;
        case (awaddr)
            ADDR_DATA: begin
                if (tx_busy || tx_start) begin  // tx_busy lags tx_start by a cycle.
                    wr_resp = RESP_SLVERR;
                end else begin
                    wr_tx = wstrb[0];
                end
            end
            ADDR_STATUS: begin
                clr_overrun = wstrb[0] && wdata[ST_OVERRUN];
                clr_frame   = wstrb[0] && wdata[ST_FRAME_ERR];
            end
            default: begin
                wr_resp = RESP_DECERR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ready_q <= 1'b0;
            bvalid     <= 1'b0;
            tx_start   <= 1'b0;
        end else begin
            wr_ready_q <= awvalid && wvalid && !bvalid && !wr_ready_q;
            tx_start   <= wr_fire && wr_tx;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
        if (wr_fire) begin
            bresp <= wr_resp;
        end
        if (wr_fire && wr_tx) begin
            tx_data <= wdata[7:0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
        if (rd_fire) begin
            case (araddr)
                ADDR_DATA: begin
                    rdata <= {24'd0, rx_hold_q};
                    rresp <= RESP_OKAY;
                end
                ADDR_STATUS: begin
                    rdata <= {28'd0, status};
                    rresp <= RESP_OKAY;
                end
                default: begin
                    rdata <= '0;
                    rresp <= RESP_DECERR;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receive data and status flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_valid_q  <= 1'b0;
            overrun_q   <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            if (new_data) begin
                rx_valid_q <= 1'b1;                   // New byte wins over a read.
            end else if (data_rd) begin
                rx_valid_q <= 1'b0;
            end
            if (new_data && rx_valid_q && !data_rd) begin
                overrun_q <= 1'b1;
            end else if (wr_fire && clr_overrun) begin
                overrun_q <= 1'b0;
            end
            if (frame_err) begin
                frame_err_q <= 1'b1;
            end else if (wr_fire && clr_frame) begin
                frame_err_q <= 1'b0;
            end
        end
        if (new_data) begin
            rx_hold_q <= rx_byte;                     // Always overwrites.
        end
    end

endmodule

// ==== verilog/uart_top.sv ====
`timescale 1ns/1ps

module uart_top (
    input  logic                clk,
    input  logic                rst,
    input  logic [3:0]          awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output axil_pkg::axi_resp_e bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [3:0]          araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output axil_pkg::axi_resp_e rresp,
    output logic                rvalid,
    input  logic                rready,
    input  logic                rx,
    output logic                tx
);

    logic [7:0] rx_byte;
    logic [7:0] tx_data;
    logic       new_data, frame_err;
    logic       tx_start, tx_busy;

    uart_regs regs (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .rx_byte, .new_data, .frame_err, .tx_busy, .tx_start, .tx_data
    );

    serial_rx receiver (
        .clk, .rst, .rx, .rx_byte, .new_data, .frame_err
    );

    serial_tx transmitter (
        .clk, .rst, .tx_start, .tx_data, .tx, .tx_busy
    );

endmodule
